// ==== logic/dot11_frame_pkg.sv ====
package dot11_frame_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // field widths of a legacy (non-HT) frame
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  rate_t;
    // length in bytes, FCS included
    typedef logic [11:0] sig_len_t;
    typedef logic [23:0] sig_bits_t;
    typedef logic [31:0] crc32_t;
    typedef logic [15:0] pkt_len_t;

    // SIGNAL field
    localparam int    SIG_BYTES       = 3;
    localparam rate_t RATE_6M         = 4'b1011;
    localparam int    SIG_DECODE_BITS = 48;

    // service field plus tail, ahead of and behind the PSDU
    localparam int SERVICE_TAIL_BITS = 22;

    ////////////////////////////////////////////////////////////////////////////
    // frame check sequence
    ////////////////////////////////////////////////////////////////////////////

    localparam crc32_t CRC32_POLY  = 32'h04C1_1DB7;
    localparam crc32_t CRC32_INIT  = 32'hFFFF_FFFF;
    // register value once the FCS bytes of a good frame are shifted in
    localparam crc32_t FCS_RESIDUE = 32'hC704_DD7B;

endpackage

// ==== logic/dot11_rx_top.sv ====
`timescale 1ns/1ps

module dot11_rx_top (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          enable_i,
    input  logic [10:0]                   rssi_half_db_i,
    input  logic [10:0]                   power_thres_i,
    input  logic                          sample_strobe_i,
    input  logic                          preamble_detected_i,
    input  dot11_frame_pkg::byte_t        byte_i,
    input  logic                          byte_strobe_i,
    output logic                          demod_is_ongoing_o,
    output logic                          pkt_begin_o,
    output logic                          pkt_header_valid_o,
    output logic                          pkt_header_valid_strobe_o,
    output dot11_frame_pkg::rate_t        pkt_rate_o,
    output dot11_frame_pkg::pkt_len_t     pkt_len_o,
    output dot11_frame_pkg::pkt_len_t     byte_count_o,
    output logic                          fcs_out_strobe_o,
    output logic                          fcs_ok_o,
    output rx_ctrl_pkg::status_t          status_code_o,
    output logic                          do_descramble_o,
    output rx_ctrl_pkg::bit_count_t       num_bits_to_decode_o
);

    signal_field_if u_sig_if ();
    fcs_if          u_fcs_if ();

    // controller
    rx_packet_ctrl u_ctrl (
        .clock                     (clock),
        .reset                     (reset),
        .enable_i                  (enable_i),
        .rssi_half_db_i            (rssi_half_db_i),
        .power_thres_i             (power_thres_i),
        .sample_strobe_i           (sample_strobe_i),
        .preamble_detected_i       (preamble_detected_i),
        .byte_i                    (byte_i),
        .byte_strobe_i             (byte_strobe_i),
        .sig                       (u_sig_if.ctrl),
        .fcs                       (u_fcs_if.ctrl),
        .demod_is_ongoing_o        (demod_is_ongoing_o),
        .pkt_begin_o               (pkt_begin_o),
        .pkt_header_valid_o        (pkt_header_valid_o),
        .pkt_header_valid_strobe_o (pkt_header_valid_strobe_o),
        .pkt_rate_o                (pkt_rate_o),
        .pkt_len_o                 (pkt_len_o),
        .byte_count_o              (byte_count_o),
        .fcs_out_strobe_o          (fcs_out_strobe_o),
        .fcs_ok_o                  (fcs_ok_o),
        .status_code_o             (status_code_o),
        .do_descramble_o           (do_descramble_o),
        .num_bits_to_decode_o      (num_bits_to_decode_o)
    );

    signal_field_check u_sig_check (
        .clock (clock),
        .reset (reset),
        .sig   (u_sig_if.check)
    );

    fcs_crc32 u_fcs (
        .clock (clock),
        .reset (reset),
        .fcs   (u_fcs_if.check)
    );

endmodule

// ==== logic/fcs_crc32.sv ====
`timescale 1ns/1ps

module fcs_crc32 (
    input logic  clock,
    input logic  reset,
    fcs_if.check fcs
);
    import dot11_frame_pkg::*;

    crc32_t crc_q;

    // one byte, lsb first, eight bit steps
    function automatic crc32_t crc_byte(input crc32_t crc_in, input byte_t data);
        crc32_t crc;
        logic   fb;
        crc = crc_in;
        for (int i = 0; i < 8; i++) begin
            fb  = crc[31] ^ data[i];
            crc = {crc[30:0], 1'b0};
            if (fb) begin
                crc = crc ^ CRC32_POLY;
            end
        end
        return crc;
    endfunction

    always_ff @(posedge clock) begin
        if (reset || fcs.clear) begin
            crc_q <= CRC32_INIT;
        end else if (fcs.enable) begin
            crc_q <= crc_byte(crc_q, fcs.byte_data);
        end
    end

    // includes every byte already enabled
    assign fcs.fcs_good = (crc_q == FCS_RESIDUE);

    a_clear_enable_excl: assert property (
        @(posedge clock) disable iff (reset)
        !(fcs.clear && fcs.enable)
    ) else $error("FCS clear and enable high together");

endmodule

// ==== logic/fcs_if.sv ====
`timescale 1ns/1ps

interface fcs_if;
    import dot11_frame_pkg::*;

    // controller side
    logic  clear;
    logic  enable;
    byte_t byte_data;

    // checker side
    logic  fcs_good;

    modport ctrl (
        output clear,
        output enable,
        output byte_data,
        input  fcs_good
    );

    modport check (
        input  clear,
        input  enable,
        input  byte_data,
        output fcs_good
    );

endinterface

// ==== logic/rx_ctrl_pkg.sv ====
package rx_ctrl_pkg;

    // receive controller states
    typedef enum logic [2:0] {
        ST_WAIT_POWER,
        ST_SYNC,
        ST_DECODE_SIGNAL,
        ST_CHECK_SIGNAL,
        ST_SIGNAL_ERROR,
        ST_DECODE_DATA,
        ST_DECODE_DONE
    } rx_state_t;

    // status codes reported with each outcome
    typedef logic [3:0] status_t;

    localparam status_t E_OK               = 4'd0;
    localparam status_t E_PARITY_FAIL      = 4'd1;
    localparam status_t E_WRONG_RSVD       = 4'd2;
    localparam status_t E_WRONG_TAIL       = 4'd3;
    localparam status_t E_UNSUPPORTED_RATE = 4'd4;
    localparam status_t E_WRONG_FCS        = 4'd5;

    // sync gives up after this many samples
    localparam int SYNC_TIMEOUT_SAMPLES = 320;
    localparam int SYNC_CNT_W           = $clog2(SYNC_TIMEOUT_SAMPLES + 2);

    typedef logic [31:0] bit_count_t;

endpackage

// ==== logic/rx_packet_ctrl.sv ====
`timescale 1ns/1ps

module rx_packet_ctrl (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          enable_i,
    input  logic [10:0]                   rssi_half_db_i,
    input  logic [10:0]                   power_thres_i,
    input  logic                          sample_strobe_i,
    input  logic                          preamble_detected_i,
    input  dot11_frame_pkg::byte_t        byte_i,
    input  logic                          byte_strobe_i,
    signal_field_if.ctrl                  sig,
    fcs_if.ctrl                           fcs,
    output logic                          demod_is_ongoing_o,
    output logic                          pkt_begin_o,
    output logic                          pkt_header_valid_o,
    output logic                          pkt_header_valid_strobe_o,
    output dot11_frame_pkg::rate_t        pkt_rate_o,
    output dot11_frame_pkg::pkt_len_t     pkt_len_o,
    output dot11_frame_pkg::pkt_len_t     byte_count_o,
    output logic                          fcs_out_strobe_o,
    output logic                          fcs_ok_o,
    output rx_ctrl_pkg::status_t          status_code_o,
    output logic                          do_descramble_o,
    output rx_ctrl_pkg::bit_count_t       num_bits_to_decode_o
);
    import dot11_frame_pkg::*;
    import rx_ctrl_pkg::*;

    rx_state_t               state_q;
    logic [SYNC_CNT_W-1:0]   sample_cnt_q;
    logic                    demod_q;
    logic                    pkt_begin_q;
    logic                    hdr_valid_q;
    logic                    hdr_strobe_q;
    rate_t                   pkt_rate_q;
    pkt_len_t                pkt_len_q;
    pkt_len_t                byte_count_q;
    logic                    fcs_strobe_q;
    logic                    fcs_ok_q;
    status_t                 status_q;
    bit_count_t              num_bits_q;

    logic power_ok;
    logic sync_timeout;
    logic data_byte;

    assign power_ok     = (rssi_half_db_i >= power_thres_i);
    assign sync_timeout = (sample_cnt_q > SYNC_TIMEOUT_SAMPLES);
    // bytes past the SIGNAL length are not counted
    assign data_byte    = (state_q == ST_DECODE_DATA) && byte_strobe_i &&
                          (byte_count_q != pkt_len_q);

    ////////////////////////////////////////////////////////////////////////////
    // SIGNAL and FCS checker hookup
    ////////////////////////////////////////////////////////////////////////////

    assign sig.capture   = (state_q == ST_DECODE_SIGNAL);
    assign sig.byte_data = byte_i;
    assign sig.byte_stb  = enable_i && byte_strobe_i && (state_q == ST_DECODE_SIGNAL);

    // register is cleared on the edge into data decoding
    assign fcs.clear     = enable_i && (state_q == ST_CHECK_SIGNAL);
    assign fcs.enable    = enable_i && data_byte;
    assign fcs.byte_data = byte_i;

    ////////////////////////////////////////////////////////////////////////////
    // receive FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q      <= ST_WAIT_POWER;
            sample_cnt_q <= '0;
            demod_q      <= 1'b0;
            pkt_begin_q  <= 1'b0;
            hdr_valid_q  <= 1'b0;
            hdr_strobe_q <= 1'b0;
            pkt_rate_q   <= '0;
            pkt_len_q    <= '0;
            byte_count_q <= '0;
            fcs_strobe_q <= 1'b0;
            fcs_ok_q     <= 1'b0;
            status_q     <= E_OK;
            num_bits_q   <= '0;
        end else if (enable_i) begin
            case (state_q)
                ST_WAIT_POWER: begin
                    demod_q <= 1'b0;
                    if (power_ok) begin
                        sample_cnt_q <= '0;
                        state_q      <= ST_SYNC;
                    end
                end

                ST_SYNC: begin
                    if (sample_strobe_i && !sync_timeout) begin
                        sample_cnt_q <= sample_cnt_q + 1'b1;
                    end
                    // power loss and timeout win over a late preamble
                    if (!power_ok || sync_timeout) begin
                        state_q <= ST_WAIT_POWER;
                    end else if (preamble_detected_i) begin
                        demod_q      <= 1'b1;
                        pkt_rate_q   <= RATE_6M;
                        num_bits_q   <= bit_count_t'(SIG_DECODE_BITS);
                        byte_count_q <= '0;
                        state_q      <= ST_DECODE_SIGNAL;
                    end
                end

                ST_DECODE_SIGNAL: begin
                    if (sig.sig_done) begin
                        hdr_strobe_q <= 1'b1;
                        hdr_valid_q  <= sig.sig_ok;
                        pkt_begin_q  <= sig.sig_ok;
                        status_q     <= sig.err_code;
                        pkt_rate_q   <= sig.rate;
                        pkt_len_q    <= pkt_len_t'(sig.len);
                        state_q      <= ST_CHECK_SIGNAL;
                    end
                end

                ST_CHECK_SIGNAL: begin
                    hdr_strobe_q <= 1'b0;
                    hdr_valid_q  <= 1'b0;
                    pkt_begin_q  <= 1'b0;
                    if (hdr_valid_q) begin
                        // 6M frames go straight on, nothing else can follow
                        num_bits_q   <= (bit_count_t'(SERVICE_TAIL_BITS) +
                                         (bit_count_t'(pkt_len_q) << 3)) << 1;
                        byte_count_q <= '0;
                        state_q      <= ST_DECODE_DATA;
                    end else begin
                        state_q <= ST_SIGNAL_ERROR;
                    end
                end

                ST_SIGNAL_ERROR: begin
                    demod_q <= 1'b0;
                    state_q <= ST_WAIT_POWER;
                end

                ST_DECODE_DATA: begin
                    if (byte_count_q == pkt_len_q) begin
                        fcs_strobe_q <= 1'b1;
                        fcs_ok_q     <= fcs.fcs_good;
                        status_q     <= fcs.fcs_good ? E_OK : E_WRONG_FCS;
                        state_q      <= ST_DECODE_DONE;
                    end else if (data_byte) begin
                        byte_count_q <= byte_count_q + 16'd1;
                    end
                end

                ST_DECODE_DONE: begin
                    fcs_strobe_q <= 1'b0;
                    fcs_ok_q     <= 1'b0;
                    demod_q      <= 1'b0;
                    state_q      <= ST_WAIT_POWER;
                end

                default: begin
                    state_q <= ST_WAIT_POWER;
                end
            endcase
        end
    end

    assign demod_is_ongoing_o        = demod_q;
    assign pkt_begin_o               = pkt_begin_q;
    assign pkt_header_valid_o        = hdr_valid_q;
    assign pkt_header_valid_strobe_o = hdr_strobe_q;
    assign pkt_rate_o                = pkt_rate_q;
    assign pkt_len_o                 = pkt_len_q;
    assign byte_count_o              = byte_count_q;
    assign fcs_out_strobe_o          = fcs_strobe_q;
    assign fcs_ok_o                  = fcs_ok_q;
    assign status_code_o             = status_q;
    assign do_descramble_o           = (state_q == ST_DECODE_DATA);
    assign num_bits_to_decode_o      = num_bits_q;

    a_fcs_strobe_pulse: assert property (
        @(posedge clock) disable iff (reset)
        fcs_strobe_q && enable_i |=> !fcs_strobe_q
    ) else $error("FCS strobe longer than one cycle");

    a_strobes_excl: assert property (
        @(posedge clock) disable iff (reset)
        !(hdr_strobe_q && fcs_strobe_q)
    ) else $error("header and FCS strobes high together");

endmodule

// ==== logic/signal_field_check.sv ====
`timescale 1ns/1ps

module signal_field_check (
    input logic           clock,
    input logic           reset,
    signal_field_if.check sig
);
    import dot11_frame_pkg::*;
    import rx_ctrl_pkg::*;

    localparam logic [1:0] LAST_BYTE = 2'(SIG_BYTES - 1);

    sig_bits_t  sig_bits_q;
    logic [1:0] byte_cnt_q;
    logic       done_q;
    logic       take_byte;

    // field split
    rate_t      rate_f;
    logic       rsvd_f;
    sig_len_t   len_f;
    logic       parity_f;
    logic [5:0] tail_f;
    logic       parity_ok;
    status_t    err_code;

    assign take_byte = sig.capture && sig.byte_stb && !done_q;

    // low byte arrives first
    always_ff @(posedge clock) begin
        if (take_byte) begin
            sig_bits_q <= {sig.byte_data, sig_bits_q[23:8]};
        end
    end

    always_ff @(posedge clock) begin
        if (reset || !sig.capture) begin
            byte_cnt_q <= '0;
            done_q     <= 1'b0;
        end else if (take_byte) begin
            if (byte_cnt_q == LAST_BYTE) begin
                byte_cnt_q <= '0;
                done_q     <= 1'b1;
            end else begin
                byte_cnt_q <= byte_cnt_q + 2'd1;
            end
        end
    end

    assign rate_f   = sig_bits_q[3:0];
    assign rsvd_f   = sig_bits_q[4];
    assign len_f    = sig_bits_q[16:5];
    assign parity_f = sig_bits_q[17];
    assign tail_f   = sig_bits_q[23:18];

    // even parity over bits 0 to 17
    assign parity_ok = ~(^sig_bits_q[16:0] ^ parity_f);

    // first failing check wins
    always_comb begin
        if (!parity_ok) begin
            err_code = E_PARITY_FAIL;
        end else if (rsvd_f) begin
            err_code = E_WRONG_RSVD;
        end else if (tail_f != 6'd0) begin
            err_code = E_WRONG_TAIL;
        end else if (!rate_f[3]) begin
            err_code = E_UNSUPPORTED_RATE;
        end else begin
            err_code = E_OK;
        end
    end

    assign sig.sig_done = done_q;
    assign sig.sig_ok   = (err_code == E_OK);
    assign sig.err_code = err_code;
    assign sig.rate     = rate_f;
    assign sig.len      = len_f;

    // the decoder must pause until the controller leaves the SIGNAL state
    a_no_byte_after_done: assert property (
        @(posedge clock) disable iff (reset)
        sig.capture && sig.byte_stb |-> !sig.sig_done
    ) else $error("SIGNAL byte strobe while sig_done is high");

endmodule

// ==== logic/signal_field_if.sv ====
`timescale 1ns/1ps

interface signal_field_if;
    import dot11_frame_pkg::*;
    import rx_ctrl_pkg::*;

    // controller side, capture is a level
    logic     capture;
    byte_t    byte_data;
    logic     byte_stb;

    // checker side, held while sig_done is high
    logic     sig_done;
    logic     sig_ok;
    status_t  err_code;
    rate_t    rate;
    sig_len_t len;

    modport ctrl (
        output capture, byte_data, byte_stb,
        input  sig_done, sig_ok, err_code, rate, len
    );

    modport check (
        input  capture, byte_data, byte_stb,
        output sig_done, sig_ok, err_code, rate, len
    );

endinterface

// ==== sim/tb_frame_tasks.svh ====
`ifndef TB_FRAME_TASKS_SVH
`define TB_FRAME_TASKS_SVH

////////////////////////////////////////////////////////////////////////////
// random source and frame contents
////////////////////////////////////////////////////////////////////////////

// fibonacci LFSR with taps 32 22 2 1
logic [31:0] lfsr_q = 32'd92118;

// data bytes then FCS bytes in air order
byte_t frame_bytes [0:63];
int    frame_len;

function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
endfunction

// one LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_bit()};
    end
    return v;
endfunction

// reflected CRC-32 of the first n bytes inverted for sending
function automatic crc32_t fcs_of_payload(input int n);
    crc32_t c;
    c = 32'hFFFF_FFFF;
    for (int i = 0; i < n; i++) begin
        c = c ^ {24'd0, frame_bytes[i]};
        for (int b = 0; b < 8; b++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
        end
    end
    return ~c;
endfunction

// len counts the four FCS bytes too
function automatic void make_frame(input int len);
    crc32_t fcs;
    for (int i = 0; i < len - 4; i++) begin
        frame_bytes[i] = byte_t'(rand_bits(8));
    end
    fcs = fcs_of_payload(len - 4);
    for (int k = 0; k < 4; k++) begin
        frame_bytes[len - 4 + k] = fcs[8*k +: 8];
    end
    frame_len = len;
endfunction

// even parity over bits 0 to 17 unless bad_parity is set
function automatic sig_bits_t build_signal(input rate_t rate, input int len, input logic rsvd,
                                           input logic [5:0] tail, input logic bad_parity);
    sig_bits_t s;
    s        = '0;
    s[3:0]   = rate;
    s[4]     = rsvd;
    s[16:5]  = sig_len_t'(len);
    s[23:18] = tail;
    s[17]    = (^s[16:0]) ^ bad_parity;
    return s;
endfunction

////////////////////////////////////////////////////////////////////////////
// driving and waiting
////////////////////////////////////////////////////////////////////////////

task automatic idle(input int n);
    repeat (n) @(negedge clock);
endtask

// sel picks the header strobe (0), data decoding (1) or the FCS strobe (2)
task automatic wait_output(input int sel, input int limit, output bit ok);
    ok = 1'b0;
    for (int n = 0; n < limit && !ok; n++) begin
        @(negedge clock);
        case (sel)
            0:       ok = pkt_header_valid_strobe_o;
            1:       ok = do_descramble_o;
            default: ok = fcs_out_strobe_o;
        endcase
    end
    if (!ok) begin
        $display("timeout at %0t ns: no response from the DUT (wait kind %0d)", $time, sel);
        error_count++;
    end
endtask

task automatic send_signal_field(input sig_bits_t s);
    for (int i = 0; i < SIG_BYTES; i++) begin
        @(negedge clock);
        byte_i        = s[8*i +: 8];
        byte_strobe_i = 1'b1;
    end
    t_sig_end = $time;
    @(negedge clock);
    byte_strobe_i = 1'b0;
endtask

task automatic send_frame(input sig_bits_t s, input logic hdr_ok, input status_t hdr_status,
                          input logic fcs_ok);
    bit ok;
    // receiver needs a few cycles to get back to sync
    idle(4);
    @(posedge clock);
    exp_hdr_valid   = hdr_ok;
    exp_status      = hdr_status;
    exp_rate        = s[3:0];
    exp_len         = pkt_len_t'(s[16:5]);
    exp_fcs_ok      = fcs_ok;
    exp_fcs_allowed = hdr_ok;
    @(negedge clock);
    preamble_detected_i = 1'b1;
    @(negedge clock);
    preamble_detected_i = 1'b0;
    a_demod_rise: assert (demod_is_ongoing_o)
        else report_mismatch("demod_is_ongoing_o not high one cycle after the preamble");
    send_signal_field(s);
    wait_output(0, 16, ok);
    if (!ok) begin
        return;
    end
    if (hdr_ok) begin
        wait_output(1, 16, ok);
        if (!ok) begin
            return;
        end
    end
    // after a rejected header these bytes must be ignored
    for (int i = 0; i < frame_len; i++) begin
        @(negedge clock);
        byte_i        = frame_bytes[i];
        byte_strobe_i = 1'b1;
    end
    t_data_end = $time;
    @(negedge clock);
    byte_strobe_i = 1'b0;
    if (hdr_ok) begin
        wait_output(2, 16, ok);
    end
endtask

`endif

// ==== sim/tb_dot11_rx.sv ====
`timescale 1ns/1ps

module tb_dot11_rx;
    import dot11_frame_pkg::*;
    import rx_ctrl_pkg::*;

    localparam time CLK_PERIOD   = 4;
    localparam int  RESET_CYCLES = 16;

    logic        clock = 1'b0;
    logic        reset = 1'b1;
    logic        enable_i;
    logic [10:0] rssi_half_db_i;
    logic [10:0] power_thres_i;
    logic        sample_strobe_i;
    logic        preamble_detected_i;
    byte_t       byte_i;
    logic        byte_strobe_i;

    logic        demod_is_ongoing_o;
    logic        pkt_begin_o;
    logic        pkt_header_valid_o;
    logic        pkt_header_valid_strobe_o;
    rate_t       pkt_rate_o;
    pkt_len_t    pkt_len_o;
    pkt_len_t    byte_count_o;
    logic        fcs_out_strobe_o;
    logic        fcs_ok_o;
    status_t     status_code_o;
    logic        do_descramble_o;
    bit_count_t  num_bits_to_decode_o;

    // expectations only change on a rising edge
    logic     exp_hdr_valid;
    status_t  exp_status;
    rate_t    exp_rate;
    pkt_len_t exp_len;
    logic     exp_fcs_ok;
    logic     exp_fcs_allowed;
    logic     demod_must_stay_low;

    time t_sig_end;
    time t_data_end;
    int  error_count;
    int  errors_at_test_start;
    int  test_num;
    int  tests_failed;

    always #(CLK_PERIOD / 2) clock = ~clock;

    dot11_rx_top u_dut (
        .clock                     (clock),
        .reset                     (reset),
        .enable_i                  (enable_i),
        .rssi_half_db_i            (rssi_half_db_i),
        .power_thres_i             (power_thres_i),
        .sample_strobe_i           (sample_strobe_i),
        .preamble_detected_i       (preamble_detected_i),
        .byte_i                    (byte_i),
        .byte_strobe_i             (byte_strobe_i),
        .demod_is_ongoing_o        (demod_is_ongoing_o),
        .pkt_begin_o               (pkt_begin_o),
        .pkt_header_valid_o        (pkt_header_valid_o),
        .pkt_header_valid_strobe_o (pkt_header_valid_strobe_o),
        .pkt_rate_o                (pkt_rate_o),
        .pkt_len_o                 (pkt_len_o),
        .byte_count_o              (byte_count_o),
        .fcs_out_strobe_o          (fcs_out_strobe_o),
        .fcs_ok_o                  (fcs_ok_o),
        .status_code_o             (status_code_o),
        .do_descramble_o           (do_descramble_o),
        .num_bits_to_decode_o      (num_bits_to_decode_o)
    );

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (error_count == errors_at_test_start) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: FAILED", test_num, name);
            tests_failed++;
        end
        errors_at_test_start = error_count;
    endtask

    task automatic expect_demod_low(input logic on);
        @(posedge clock);
        demod_must_stay_low = on;
    endtask

    `include "tb_frame_tasks.svh"

    ////////////////////////////////////////////////////////////////////////////
    // checks sampled mid-cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (!reset) begin
            if (pkt_header_valid_strobe_o) begin
                a_hdr_time: assert ($time - t_sig_end == 2 * CLK_PERIOD)
                    else report_mismatch("header strobe not 2 cycles after SIGNAL");
                a_hdr_valid: assert (pkt_header_valid_o == exp_hdr_valid)
                    else report_mismatch($sformatf("header valid %0b, expected %0b",
                                                   pkt_header_valid_o, exp_hdr_valid));
                a_hdr_begin: assert (pkt_begin_o == exp_hdr_valid)
                    else report_mismatch("pkt_begin_o does not follow header result");
                a_hdr_status: assert (status_code_o == exp_status)
                    else report_mismatch($sformatf("header status %0d, expected %0d",
                                                   status_code_o, exp_status));
                a_sig_bits: assert (num_bits_to_decode_o == bit_count_t'(SIG_DECODE_BITS))
                    else report_mismatch($sformatf("bits to decode %0d for SIGNAL",
                                                   num_bits_to_decode_o));
                if (exp_hdr_valid) begin
                    a_hdr_rate: assert (pkt_rate_o == exp_rate)
                        else report_mismatch($sformatf("rate %b, expected %b",
                                                       pkt_rate_o, exp_rate));
                    a_hdr_len: assert (pkt_len_o == exp_len)
                        else report_mismatch($sformatf("length %0d, expected %0d",
                                                       pkt_len_o, exp_len));
                end
            end
            if (fcs_out_strobe_o) begin
                a_fcs_allowed: assert (exp_fcs_allowed)
                    else begin
                        $display("FCS strobe at %0t ns after a rejected header", $time);
                        error_count++;
                    end
                a_fcs_time: assert ($time - t_data_end == 2 * CLK_PERIOD)
                    else report_mismatch("FCS strobe not 2 cycles after last byte");
                a_fcs_ok: assert (fcs_ok_o == exp_fcs_ok)
                    else report_mismatch($sformatf("fcs_ok %0b, expected %0b",
                                                   fcs_ok_o, exp_fcs_ok));
                a_fcs_status: assert (status_code_o == (exp_fcs_ok ? E_OK : E_WRONG_FCS))
                    else report_mismatch($sformatf("FCS status %0d", status_code_o));
                a_fcs_count: assert (byte_count_o == exp_len)
                    else report_mismatch($sformatf("byte count %0d, expected %0d",
                                                   byte_count_o, exp_len));
            end
            // 16 bits of service plus 6 tail bits at rate 1/2
            if (do_descramble_o) begin
                a_num_bits: assert (num_bits_to_decode_o ==
                                    bit_count_t'((22 + 8 * int'(exp_len)) * 2))
                    else report_mismatch($sformatf("bits to decode %0d",
                                                   num_bits_to_decode_o));
            end
            if (demod_must_stay_low) begin
                a_demod_low: assert (!demod_is_ongoing_o)
                    else begin
                        $display("demodulation started at %0t ns after sync was lost", $time);
                        error_count++;
                    end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int        len;
        int        idx;
        rate_t     rate;
        logic      bad;
        sig_bits_t sig;

        enable_i             = 1'b1;
        rssi_half_db_i       = 11'd400;
        power_thres_i        = 11'd200;
        sample_strobe_i      = 1'b0;
        preamble_detected_i  = 1'b0;
        byte_i               = '0;
        byte_strobe_i        = 1'b0;
        exp_hdr_valid        = 1'b0;
        exp_status           = E_OK;
        exp_rate             = '0;
        exp_len              = '0;
        exp_fcs_ok           = 1'b0;
        exp_fcs_allowed      = 1'b0;
        demod_must_stay_low  = 1'b0;
        t_sig_end            = 0;
        t_data_end           = 0;
        error_count          = 0;
        errors_at_test_start = 0;
        test_num             = 0;
        tests_failed         = 0;

        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        idle(2);

        make_frame(24);
        sig = build_signal(4'b1101, 24, 1'b0, 6'd0, 1'b0);
        send_frame(sig, 1'b1, E_OK, 1'b1);
        end_test("good frame");

        frame_bytes[5] = frame_bytes[5] ^ 8'h20;
        send_frame(sig, 1'b1, E_OK, 1'b0);
        end_test("payload byte flipped");

        // each case also breaks every lower priority check
        send_frame(build_signal(4'b0101, 20, 1'b1, 6'h3, 1'b1), 1'b0, E_PARITY_FAIL, 1'b0);
        send_frame(build_signal(4'b0101, 20, 1'b1, 6'h3, 1'b0), 1'b0, E_WRONG_RSVD, 1'b0);
        send_frame(build_signal(4'b0101, 20, 1'b0, 6'h3, 1'b0), 1'b0, E_WRONG_TAIL, 1'b0);
        send_frame(build_signal(4'b0101, 20, 1'b0, 6'h0, 1'b0), 1'b0,
                   E_UNSUPPORTED_RATE, 1'b0);
        idle(4);
        end_test("SIGNAL errors");

        expect_demod_low(1'b1);
        @(negedge clock);
        rssi_half_db_i = 11'd100;
        @(negedge clock);
        preamble_detected_i = 1'b1;
        @(negedge clock);
        preamble_detected_i = 1'b0;
        idle(4);
        rssi_half_db_i = 11'd400;
        idle(4);
        end_test("power drop in sync");

        // preamble lands on the cycle the timeout is taken
        repeat (SYNC_TIMEOUT_SAMPLES + 1) begin
            @(negedge clock);
            sample_strobe_i = 1'b1;
        end
        @(negedge clock);
        sample_strobe_i     = 1'b0;
        preamble_detected_i = 1'b1;
        @(negedge clock);
        preamble_detected_i = 1'b0;
        idle(4);
        expect_demod_low(1'b0);
        make_frame(16);
        send_frame(build_signal(4'b1101, 16, 1'b0, 6'd0, 1'b0), 1'b1, E_OK, 1'b1);
        end_test("sync timeout");

        for (int f = 0; f < 8; f++) begin
            len  = 4 + (int'(rand_bits(6)) % 37);
            rate = {1'b1, 3'(rand_bits(3))};
            bad  = rand_bits(1);
            make_frame(len);
            if (bad) begin
                idx = int'(rand_bits(6)) % len;
                frame_bytes[idx] = frame_bytes[idx] ^ (byte_t'(rand_bits(8)) | 8'h01);
            end
            send_frame(build_signal(rate, len, 1'b0, 6'd0, 1'b0), 1'b1, E_OK, !bad);
        end
        end_test("random frames");

        $display("summary: %0d tests, %0d failed, %0d errors",
                 test_num, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+sim
logic/dot11_frame_pkg.sv
logic/rx_ctrl_pkg.sv
logic/signal_field_if.sv
logic/fcs_if.sv
logic/signal_field_check.sv
logic/fcs_crc32.sv
logic/rx_packet_ctrl.sv
logic/dot11_rx_top.sv
sim/tb_dot11_rx.sv
